// ==== logic/lane_defines.svh ====
`ifndef LANE_DEFINES_SVH
`define LANE_DEFINES_SVH

// hardware threads sharing one lane
`define LANE_THREADS 4
// registers per thread
`define LANE_REGS 32
// datapath word width
`define LANE_XLEN 32

// index widths follow from the counts
`define LANE_THREAD_W $clog2(`LANE_THREADS)
`define LANE_REG_W $clog2(`LANE_REGS)

// wishbone byte address, 12 bits
`define LANE_WB_AW 12
// set selects the register window, clear is the issue address
`define LANE_WIN_BIT 11
// thread index lives in adr[8:7] inside the window
`define LANE_WIN_THREAD_LSB 7
// register index in adr[6:2], word aligned
`define LANE_WIN_REG_LSB 2

// result of an instruction with no valid class
`define LANE_INVALID_WORD 32'hdeadbeef

`endif

// ==== logic/lane_pkg.sv ====
`include "lane_defines.svh"

package lane_pkg;

    // execution unit that serves an instruction
    typedef enum logic [1:0] {
        class_invalid = 2'd0,
        class_int     = 2'd1,
        class_float   = 2'd2
    } op_class_e;

    // integer function codes, codes 12..15 give zero
    typedef enum logic [3:0] {
        int_add  = 4'd0,
        int_sub  = 4'd1,
        int_and  = 4'd2,
        int_or   = 4'd3,
        int_xor  = 4'd4,
        int_sll  = 4'd5,
        int_srl  = 4'd6,
        int_sra  = 4'd7,
        int_slt  = 4'd8,
        int_sltu = 4'd9,
        int_eq   = 4'd10,
        int_ne   = 4'd11
    } int_funct_e;

    // float function codes, codes 10..15 give zero
    typedef enum logic [3:0] {
        flt_min   = 4'd0,
        flt_max   = 4'd1,
        flt_neg   = 4'd2,
        flt_abs   = 4'd3,
        flt_sgnj  = 4'd4,
        flt_sgnjn = 4'd5,
        flt_sgnjx = 4'd6,
        flt_eq    = 4'd7,
        flt_lt    = 4'd8,
        flt_le    = 4'd9
    } float_funct_e;

    // one issued instruction, msb first
    typedef struct packed {
        op_class_e                op_class;
        // decoded as int_funct_e or float_funct_e by class
        logic [3:0]               funct;
        logic [`LANE_THREAD_W-1:0] thread;
        logic [`LANE_REG_W-1:0]    ad1;
        logic [`LANE_REG_W-1:0]    ad2;
        logic [`LANE_REG_W-1:0]    ad3;
        logic                     we;
        logic [7:0]               reserved;
    } lane_instr_t;

    // register word, raw or as float fields
    typedef union packed {
        logic [`LANE_XLEN-1:0] raw;
        struct packed {
            logic        sign;
            logic [7:0]  exponent;
            logic [22:0] mantissa;
        } fp;
    } lane_word_u;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`LANE_WB_AW-1:0] adr;
        logic [`LANE_XLEN-1:0]  dat;
    } wb_req_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic                  ack;
        logic [`LANE_XLEN-1:0] dat;
    } wb_rsp_t;

    // single register write
    typedef struct packed {
        logic                      en;
        logic [`LANE_THREAD_W-1:0] thread;
        logic [`LANE_REG_W-1:0]    addr;
        logic [`LANE_XLEN-1:0]     data;
    } rf_write_t;

endpackage

// ==== logic/thread_regfile.sv ====
`timescale 1ns/100ps
`include "lane_defines.svh"

module thread_regfile (
    input  logic                      clk,

    // read port 1, also used for register window reads
    input  logic [`LANE_THREAD_W-1:0] rd1_thread,
    input  logic [`LANE_REG_W-1:0]    rd1_addr,
    output logic [`LANE_XLEN-1:0]     rd1_data,

    // read port 2
    input  logic [`LANE_THREAD_W-1:0] rd2_thread,
    input  logic [`LANE_REG_W-1:0]    rd2_addr,
    output logic [`LANE_XLEN-1:0]     rd2_data,

    // write-back or direct load, already muxed
    input  lane_pkg::rf_write_t       wr
);

    // one bank of registers per thread
    logic [`LANE_XLEN-1:0] regs [`LANE_THREADS][`LANE_REGS];

    // asynchronous reads
    // a write in the same cycle is not visible here, the lane bypasses it
    assign rd1_data = regs[rd1_thread][rd1_addr];
    assign rd2_data = regs[rd2_thread][rd2_addr];

    // single synchronous write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            regs[wr.thread][wr.addr] <= wr.data;
        end
    end

endmodule

// ==== logic/int_alu.sv ====
`timescale 1ns/100ps
`include "lane_defines.svh"

module int_alu (
    input  logic [`LANE_XLEN-1:0] op1,
    input  logic [`LANE_XLEN-1:0] op2,
    input  lane_pkg::int_funct_e  funct,
    output logic [`LANE_XLEN-1:0] result
);

    // shift amount from the low five bits only
    logic [4:0] shamt;

    // compare outcomes, widened to a word below
    logic lt_signed;
    logic lt_unsigned;

    assign shamt       = op2[4:0];
    assign lt_signed   = $signed(op1) < $signed(op2);
    assign lt_unsigned = op1 < op2;

    always_comb begin
        case (funct)
            lane_pkg::int_add:  result = op1 + op2;
            lane_pkg::int_sub:  result = op1 - op2;
            lane_pkg::int_and:  result = op1 & op2;
            lane_pkg::int_or:   result = op1 | op2;
            lane_pkg::int_xor:  result = op1 ^ op2;
            lane_pkg::int_sll:  result = op1 << shamt;
            lane_pkg::int_srl:  result = op1 >> shamt;
            // arithmetic shift keeps the sign bit
            lane_pkg::int_sra:  result = $signed(op1) >>> shamt;
            // compares yield 1 or 0
            lane_pkg::int_slt:  result = {{(`LANE_XLEN-1){1'b0}}, lt_signed};
            lane_pkg::int_sltu: result = {{(`LANE_XLEN-1){1'b0}}, lt_unsigned};
            lane_pkg::int_eq:   result = {{(`LANE_XLEN-1){1'b0}}, op1 == op2};
            lane_pkg::int_ne:   result = {{(`LANE_XLEN-1){1'b0}}, op1 != op2};
            // undefined codes
            default:            result = '0;
        endcase
    end

endmodule

// ==== logic/float_alu.sv ====
`timescale 1ns/100ps
`include "lane_defines.svh"

module float_alu (
    input  lane_pkg::lane_word_u   op1,
    input  lane_pkg::lane_word_u   op2,
    input  lane_pkg::float_funct_e funct,
    output logic [`LANE_XLEN-1:0]  result
);

    // exponent and mantissa together order as an unsigned magnitude
    logic [`LANE_XLEN-2:0] mag1;
    logic [`LANE_XLEN-2:0] mag2;

    logic both_zero;
    logic eq;
    logic lt;

    // result before it leaves as a raw word
    lane_pkg::lane_word_u res;

    assign mag1 = {op1.fp.exponent, op1.fp.mantissa};
    assign mag2 = {op2.fp.exponent, op2.fp.mantissa};

    // +0 and -0 compare equal
    assign both_zero = (mag1 == '0) && (mag2 == '0);
    assign eq        = both_zero || (op1.raw == op2.raw);

    // order by sign first, then by magnitude
    always_comb begin
        if (both_zero) begin
            lt = 1'b0;
        end else if (op1.fp.sign != op2.fp.sign) begin
            // negative op1 is the smaller one
            lt = op1.fp.sign;
        end else if (op1.fp.sign) begin
            // both negative, larger magnitude is smaller
            lt = mag1 > mag2;
        end else begin
            lt = mag1 < mag2;
        end
    end

    always_comb begin
        // op1 magnitude by default, only the sign changes
        res = op1;
        case (funct)
            lane_pkg::flt_min:   res = lt ? op1 : op2;
            lane_pkg::flt_max:   res = lt ? op2 : op1;
            lane_pkg::flt_neg:   res.fp.sign = ~op1.fp.sign;
            lane_pkg::flt_abs:   res.fp.sign = 1'b0;
            // sign injection from op2
            lane_pkg::flt_sgnj:  res.fp.sign = op2.fp.sign;
            lane_pkg::flt_sgnjn: res.fp.sign = ~op2.fp.sign;
            lane_pkg::flt_sgnjx: res.fp.sign = op1.fp.sign ^ op2.fp.sign;
            // compares as 1 or 0
            lane_pkg::flt_eq:    res.raw = {{(`LANE_XLEN-1){1'b0}}, eq};
            lane_pkg::flt_lt:    res.raw = {{(`LANE_XLEN-1){1'b0}}, lt};
            lane_pkg::flt_le:    res.raw = {{(`LANE_XLEN-1){1'b0}}, lt | eq};
            default:             res.raw = '0;
        endcase
    end

    assign result = res.raw;

endmodule

// ==== logic/lane.sv ====
`timescale 1ns/100ps
`include "lane_defines.svh"

module lane (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      issue_valid,
    input  lane_pkg::lane_instr_t     issue_instr,
    input  lane_pkg::rf_write_t       load,
    input  logic [`LANE_THREAD_W-1:0] peek_thread,
    input  logic [`LANE_REG_W-1:0]    peek_addr,
    output logic [`LANE_XLEN-1:0]     peek_data,
    output logic                      busy
);

    // stage one, operand read
    logic [`LANE_THREAD_W-1:0] rd1_thread;
    logic [`LANE_REG_W-1:0]    rd1_addr;
    logic [`LANE_XLEN-1:0]     rd1_data;
    logic [`LANE_XLEN-1:0]     rd2_data;
    logic                      byp1;
    logic                      byp2;
    logic [`LANE_XLEN-1:0]     op1;
    logic [`LANE_XLEN-1:0]     op2;

    // stage two, execute and write-back
    logic                      s2_valid;
    lane_pkg::lane_instr_t     s2_instr;
    lane_pkg::lane_word_u      s2_op1;
    lane_pkg::lane_word_u      s2_op2;
    logic [`LANE_XLEN-1:0]     int_result;
    logic [`LANE_XLEN-1:0]     flt_result;
    logic [`LANE_XLEN-1:0]     s2_result;
    logic                      s2_writes;
    lane_pkg::rf_write_t       rf_wr;

    // port 1 serves the register window while nothing issues
    assign rd1_thread = issue_valid ? issue_instr.thread : peek_thread;
    assign rd1_addr   = issue_valid ? issue_instr.ad1 : peek_addr;
    assign peek_data  = rd1_data;

    thread_regfile u_regfile (
        .clk        (clk),
        .rd1_thread (rd1_thread),
        .rd1_addr   (rd1_addr),
        .rd1_data   (rd1_data),
        .rd2_thread (issue_instr.thread),
        .rd2_addr   (issue_instr.ad2),
        .rd2_data   (rd2_data),
        .wr         (rf_wr)
    );

    // forward the stage-two result when it lands on a source this edge
    assign s2_writes = s2_valid & s2_instr.we;
    assign byp1 = s2_writes && (s2_instr.thread == issue_instr.thread)
                  && (s2_instr.ad3 == issue_instr.ad1);
    assign byp2 = s2_writes && (s2_instr.thread == issue_instr.thread)
                  && (s2_instr.ad3 == issue_instr.ad2);
    assign op1 = byp1 ? s2_result : rd1_data;
    assign op2 = byp2 ? s2_result : rd2_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= issue_valid;
        end
    end

    // instruction and operands move on together
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            s2_instr   <= issue_instr;
            s2_op1.raw <= op1;
            s2_op2.raw <= op2;
        end
    end

    int_alu u_int_alu (
        .op1    (s2_op1.raw),
        .op2    (s2_op2.raw),
        .funct  (lane_pkg::int_funct_e'(s2_instr.funct)),
        .result (int_result)
    );

    float_alu u_float_alu (
        .op1    (s2_op1),
        .op2    (s2_op2),
        .funct  (lane_pkg::float_funct_e'(s2_instr.funct)),
        .result (flt_result)
    );

    // class picks the unit, anything else is the invalid marker
    always_comb begin
        case (s2_instr.op_class)
            lane_pkg::class_int:   s2_result = int_result;
            lane_pkg::class_float: s2_result = flt_result;
            default:               s2_result = `LANE_INVALID_WORD;
        endcase
    end

    // write-back wins; loads only arrive while the lane is idle
    always_comb begin
        if (s2_writes) begin
            rf_wr.en     = 1'b1;
            rf_wr.thread = s2_instr.thread;
            rf_wr.addr   = s2_instr.ad3;
            rf_wr.data   = s2_result;
        end else begin
            rf_wr = load;
        end
    end

    // in flight means in either stage
    assign busy = issue_valid | s2_valid;

endmodule

// ==== logic/wb_lane_port.sv ====
`timescale 1ns/100ps
`include "lane_defines.svh"

module wb_lane_port (
    input  logic                      clk,
    input  logic                      reset,
    input  lane_pkg::wb_req_t         wb_req,
    output lane_pkg::wb_rsp_t         wb_rsp,
    output logic                      issue_valid,
    output lane_pkg::lane_instr_t     issue_instr,
    output lane_pkg::rf_write_t       load,
    output logic [`LANE_THREAD_W-1:0] peek_thread,
    output logic [`LANE_REG_W-1:0]    peek_addr,
    input  logic [`LANE_XLEN-1:0]     peek_data,
    input  logic                      busy
);

    logic                  win_hit;
    logic                  start;
    logic                  ack_q;
    logic                  acc_active;
    logic                  issue_valid_q;
    lane_pkg::lane_instr_t issue_instr_q;
    logic [`LANE_XLEN-1:0] rdat_q;

    assign win_hit = wb_req.adr[`LANE_WIN_BIT];

    // new transfer, not one already being served or acked
    assign start = wb_req.cyc & wb_req.stb & ~ack_q & ~acc_active;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q         <= 1'b0;
            acc_active    <= 1'b0;
            issue_valid_q <= 1'b0;
        end else begin
            ack_q         <= 1'b0;
            issue_valid_q <= 1'b0;
            if (acc_active) begin
                // window access done, ack next cycle
                acc_active <= 1'b0;
                ack_q      <= 1'b1;
            end else if (start && !win_hit) begin
                // issue address never stalls
                ack_q         <= 1'b1;
                issue_valid_q <= wb_req.we;
            end else if (start && !busy) begin
                // window waits for the pipeline to drain
                acc_active <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !win_hit) begin
            issue_instr_q <= lane_pkg::lane_instr_t'(wb_req.dat);
        end
        // reads of the issue address return zero
        if (acc_active) begin
            rdat_q <= peek_data;
        end else if (start && !win_hit) begin
            rdat_q <= '0;
        end
    end

    // window fields come straight off the bus, held until ack
    assign peek_thread = wb_req.adr[`LANE_WIN_THREAD_LSB +: `LANE_THREAD_W];
    assign peek_addr   = wb_req.adr[`LANE_WIN_REG_LSB +: `LANE_REG_W];

    always_comb begin
        load.en     = acc_active & wb_req.we;
        load.thread = peek_thread;
        load.addr   = peek_addr;
        load.data   = wb_req.dat;
    end

    assign issue_valid = issue_valid_q;
    assign issue_instr = issue_instr_q;
    assign wb_rsp.ack  = ack_q;
    assign wb_rsp.dat  = rdat_q;

endmodule

// ==== logic/simt_lane_top.sv ====
`timescale 1ns/100ps
`include "lane_defines.svh"

module simt_lane_top (
    input  logic              clk,
    input  logic              reset,
    input  lane_pkg::wb_req_t wb_req,
    output lane_pkg::wb_rsp_t wb_rsp
);

    // port to lane
    logic                      issue_valid;
    lane_pkg::lane_instr_t     issue_instr;
    lane_pkg::rf_write_t       load;
    logic [`LANE_THREAD_W-1:0] peek_thread;
    logic [`LANE_REG_W-1:0]    peek_addr;

    // lane to port
    logic [`LANE_XLEN-1:0]     peek_data;
    logic                      busy;

    // bus side, address decode and ack
    wb_lane_port u_port (
        .clk         (clk),
        .reset       (reset),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .load        (load),
        .peek_thread (peek_thread),
        .peek_addr   (peek_addr),
        .peek_data   (peek_data),
        .busy        (busy)
    );

    // registers, both alus, two stages
    lane u_lane (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .load        (load),
        .peek_thread (peek_thread),
        .peek_addr   (peek_addr),
        .peek_data   (peek_data),
        .busy        (busy)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD        = 100,
    parameter int RESET_CYCLES  = 5,
    parameter int RELEASE_DELAY = 10
) (
    output logic clk,
    output logic reset
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // synchronous reset, released a little after a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #RELEASE_DELAY;
        reset = 1'b0;
    end

endmodule

// ==== tb/tb_lane.sv ====
`timescale 1ns/100ps
`include "lane_defines.svh"

module tb_lane;

    // inputs change this long after the rising edge
    localparam int DRIVE_DELAY   = 10;
    localparam int ACK_TIMEOUT   = 20;
    localparam int RESET_TIMEOUT = 20;

    logic              clk;
    logic              reset;
    lane_pkg::wb_req_t wb_req;
    lane_pkg::wb_rsp_t wb_rsp;

    // reference copy of every thread's registers
    logic [31:0] model_regs [`LANE_THREADS][`LANE_REGS];

    int errors    = 0;
    int timeouts  = 0;
    int transfers = 0;
    int acks_seen = 0;

    tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(5), .RELEASE_DELAY(DRIVE_DELAY)) u_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    simt_lane_top dut0 (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    // ack cycles sampled mid-cycle where ack is stable
    always @(negedge clk) begin
        if (wb_rsp.ack === 1'b1) begin
            acks_seen++;
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got=%08h exp=%08h", $time, name, got, exp);
        end
    endtask

    task automatic end_run();
        $display("errors=%0d timeouts=%0d transfers=%0d acks=%0d",
                 errors, timeouts, transfers, acks_seen);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // window address with bit 11 set and thread and register fields below
    function automatic logic [11:0] win_addr(input int thr, input int r);
        logic [11:0] a;
        a = '0;
        a[`LANE_WIN_BIT] = 1'b1;
        a[`LANE_WIN_THREAD_LSB +: 2] = thr[1:0];
        a[`LANE_WIN_REG_LSB +: 5] = r[4:0];
        return a;
    endfunction

    // one classic cycle started a drive delay after a rising edge
    task automatic wb_transfer(input logic we, input logic [11:0] adr,
                               input logic [31:0] wdat, output logic [31:0] rdat);
        int cycles;
        rdat = '0;
        // bus stays idle once an ack went missing
        if (timeouts == 0) begin
            wb_req.cyc = 1'b1;
            wb_req.stb = 1'b1;
            wb_req.we  = we;
            wb_req.adr = adr;
            wb_req.dat = wdat;
            cycles = 0;
            do begin
                @(posedge clk);
                #DRIVE_DELAY;
                cycles++;
            end while (wb_rsp.ack !== 1'b1 && cycles < ACK_TIMEOUT);
            if (wb_rsp.ack !== 1'b1) begin
                $display("timeout: no ack for address %03h after %0d cycles",
                         adr, ACK_TIMEOUT);
                timeouts++;
            end else begin
                rdat = wb_rsp.dat;
                transfers++;
                // issue address never stalls
                if (!adr[`LANE_WIN_BIT]) begin
                    compare("wb_rsp.ack latency", cycles, 32'd1);
                end
                wb_req.cyc = 1'b0;
                wb_req.stb = 1'b0;
                wb_req.we  = 1'b0;
                // ack must be gone after one idle cycle
                @(posedge clk);
                #DRIVE_DELAY;
                compare("wb_rsp.ack", {31'b0, wb_rsp.ack}, 32'd0);
            end
        end
    endtask

    task automatic reg_write(input int thr, input int r, input logic [31:0] val);
        logic [31:0] unused;
        wb_transfer(1'b1, win_addr(thr, r), val, unused);
        model_regs[thr][r] = val;
    endtask

    task automatic reg_check(input int thr, input int r);
        logic [31:0] got;
        wb_transfer(1'b0, win_addr(thr, r), 32'h0, got);
        if (timeouts == 0) begin
            compare($sformatf("wb_rsp.dat t%0d r%0d", thr, r), got, model_regs[thr][r]);
        end
    endtask

    function automatic logic [31:0] int_model(input logic [3:0] f, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [63:0] ext;
        // sign-extended copy for the arithmetic shift
        ext = {{32{a[31]}}, a} >> b[4:0];
        case (f)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return a & b;
            4'd3:    return a | b;
            4'd4:    return a ^ b;
            4'd5:    return a << b[4:0];
            4'd6:    return a >> b[4:0];
            4'd7:    return ext[31:0];
            // signed order by flipping the sign bits
            4'd8:    return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            4'd9:    return {31'b0, a < b};
            4'd10:   return {31'b0, a == b};
            4'd11:   return {31'b0, a != b};
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] float_model(input logic [3:0] f, input logic [31:0] a,
                                                input logic [31:0] b);
        longint ka;
        longint kb;
        logic   lt;
        logic   eq;
        // signed key puts -0 and +0 on the same value
        ka = a[31] ? -longint'(a[30:0]) : longint'(a[30:0]);
        kb = b[31] ? -longint'(b[30:0]) : longint'(b[30:0]);
        lt = ka < kb;
        eq = ka == kb;
        case (f)
            4'd0:    return lt ? a : b;
            4'd1:    return lt ? b : a;
            4'd2:    return {~a[31], a[30:0]};
            4'd3:    return {1'b0, a[30:0]};
            4'd4:    return {b[31], a[30:0]};
            4'd5:    return {~b[31], a[30:0]};
            4'd6:    return {a[31] ^ b[31], a[30:0]};
            4'd7:    return {31'b0, eq};
            4'd8:    return {31'b0, lt};
            4'd9:    return {31'b0, lt | eq};
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] model_result(input logic [1:0] cls, input logic [3:0] f,
                                                 input logic [31:0] a, input logic [31:0] b);
        case (cls)
            2'd1:    return int_model(f, a, b);
            2'd2:    return float_model(f, a, b);
            default: return 32'hdeadbeef;
        endcase
    endfunction

    // second operand as signed zero, same magnitude or equal copy of the first
    function automatic logic [31:0] related_operand(input logic [31:0] other);
        logic [31:0] v;
        v = $urandom;
        case ($urandom_range(3, 0))
            0:       v[30:0] = '0;
            1:       v[30:0] = other[30:0];
            2:       v = other;
            default: v = v;
        endcase
        return v;
    endfunction

    task automatic issue(input logic [1:0] cls, input logic [3:0] f, input int thr,
                         input int a1, input int a2, input int a3, input logic we);
        lane_pkg::lane_instr_t ins;
        logic [31:0]           res;
        logic [31:0]           unused;
        ins.op_class = lane_pkg::op_class_e'(cls);
        ins.funct    = f;
        ins.thread   = thr[1:0];
        ins.ad1      = a1[4:0];
        ins.ad2      = a2[4:0];
        ins.ad3      = a3[4:0];
        ins.we       = we;
        ins.reserved = 8'($urandom);
        // sources as the model holds them before this instruction
        res = model_result(cls, f, model_regs[thr][a1], model_regs[thr][a2]);
        wb_transfer(1'b1, 12'h000, ins, unused);
        if (we) begin
            model_regs[thr][a3] = res;
        end
    endtask

    task automatic random_op(input logic [1:0] cls);
        int          thr;
        int          a1;
        int          a2;
        int          a3;
        logic [31:0] v1;
        thr = $urandom_range(3, 0);
        a1  = $urandom_range(31, 0);
        a2  = $urandom_range(31, 0);
        a3  = $urandom_range(31, 0);
        v1  = $urandom;
        // zero first operand now and then so +0 and -0 meet
        if (cls == 2'd2 && $urandom_range(3, 0) == 0) begin
            v1[30:0] = '0;
        end
        reg_write(thr, a1, v1);
        reg_write(thr, a2, related_operand(v1));
        issue(cls, 4'($urandom), thr, a1, a2, a3, 1'b1);
        reg_check(thr, a3);
    endtask

    // each instruction reads the destination of the one before
    task automatic dependent_chain();
        int thr;
        int prev;
        int src;
        int dsts[4];
        thr  = $urandom_range(3, 0);
        prev = $urandom_range(31, 0);
        for (int i = 0; i < 4; i++) begin
            dsts[i] = $urandom_range(31, 0);
            src     = $urandom_range(31, 0);
            if ($urandom_range(1, 0) == 1) begin
                issue(2'($urandom_range(2, 1)), 4'($urandom), thr, prev, src, dsts[i], 1'b1);
            end else begin
                issue(2'($urandom_range(2, 1)), 4'($urandom), thr, src, prev, dsts[i], 1'b1);
            end
            prev = dsts[i];
        end
        for (int i = 0; i < 4; i++) begin
            reg_check(thr, dsts[i]);
        end
    endtask

    initial begin
        int         k;
        logic [1:0] cls;
        wb_req = '0;
        void'($urandom(32'hcb46_e8d6));
        k = 0;
        while (reset !== 1'b0 && k < RESET_TIMEOUT) begin
            @(posedge clk);
            k++;
        end
        if (reset !== 1'b0) begin
            $display("reset was never released");
            timeouts++;
        end else begin
            @(posedge clk);
            #DRIVE_DELAY;
        end

        // fill every register of every thread and read all back
        for (int t = 0; t < `LANE_THREADS; t++) begin
            for (int r = 0; r < `LANE_REGS; r++) begin
                reg_write(t, r, $urandom);
            end
        end
        repeat (64) reg_write($urandom_range(3, 0), $urandom_range(31, 0), $urandom);
        for (int t = 0; t < `LANE_THREADS; t++) begin
            for (int r = 0; r < `LANE_REGS; r++) begin
                reg_check(t, r);
            end
        end

        // integer class first and float class after
        repeat (200) random_op(2'd1);
        repeat (200) random_op(2'd2);

        repeat (20) dependent_chain();

        // invalid classes write the marker
        repeat (20) begin
            cls = ($urandom_range(1, 0) == 1) ? 2'd3 : 2'd0;
            k   = $urandom_range(31, 0);
            issue(cls, 4'($urandom), 0, $urandom_range(31, 0), 0, k, 1'b1);
            reg_check(0, k);
        end
        // with we clear the register keeps its value
        repeat (40) begin
            k = $urandom_range(31, 0);
            issue(2'($urandom), 4'($urandom), 1, $urandom_range(31, 0), 2, k, 1'b0);
            reg_check(1, k);
        end

        if (timeouts == 0) begin
            compare("wb_rsp.ack count", acks_seen, transfers);
        end
        end_run();
    end

endmodule

// ==== flist.f ====
+incdir+logic
logic/lane_pkg.sv
logic/thread_regfile.sv
logic/int_alu.sv
logic/float_alu.sv
logic/lane.sv
logic/wb_lane_port.sv
logic/simt_lane_top.sv
tb/tb_clock_gen.sv
tb/tb_lane.sv
